//--- source/maze_geometry_pkg.sv
`default_nettype none

package maze_geometry_pkg;

    // Maze size in tiles
    localparam int grid_w = 29;
    localparam int grid_h = 13;

    localparam int tile_px = 5;   // Tile edge in pixels

    // Canvas in pixels, one 12-bit word each
    localparam int canvas_w     = 160;
    localparam int canvas_h     = 120;
    localparam int canvas_words = canvas_w * canvas_h;

    localparam int food_offset = 2;   // Dot sits at tile centre

    // Tile coordinates
    typedef logic [4:0] tile_x_t;   // 0..28
    typedef logic [3:0] tile_y_t;   // 0..12

    typedef logic [2:0] sub_t;   // Pixel offset inside a tile

    typedef logic [14:0] fb_addr_t;   // Canvas word address

    // Canvas pixel coordinates
    typedef logic [7:0] canvas_x_t;
    typedef logic [6:0] canvas_y_t;

    // Step direction, encoding shared with the input port
    typedef enum logic [1:0] {
        up    = 2'd0,
        left  = 2'd1,
        down  = 2'd2,
        right = 2'd3
    } direction_t;

endpackage

`default_nettype wire

//--- source/render_pkg.sv
`default_nettype none

package render_pkg;

    import maze_geometry_pkg::*;

    typedef logic [11:0] color_t;   // 4 bits per channel

    localparam color_t color_wall   = 12'h0FF;
    localparam color_t color_floor  = 12'h000;
    localparam color_t color_food   = 12'hFFF;
    localparam color_t color_player = 12'hFA8;

    // Draw order of one frame
    typedef enum logic [1:0] {
        draw_maze   = 2'd0,
        draw_food   = 2'd1,
        draw_player = 2'd2
    } phase_t;

    // Walker to lookup, 18 bits
    typedef struct packed {
        logic    valid;
        phase_t  phase;
        tile_x_t tile_x;
        tile_y_t tile_y;
        sub_t    dx;
        sub_t    dy;
    } walk_item_t;

    // Lookup to frame buffer, 28 bits
    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
        color_t   color;
    } pixel_write_t;

    // Player tile after reset
    localparam tile_x_t start_tile_x = 5'd1;
    localparam tile_y_t start_tile_y = 4'd1;

endpackage

`default_nettype wire

//--- source/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer
    import maze_geometry_pkg::*, render_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       step,         // One-cycle request
    input  direction_t direction,
    input  logic       probe_wall,   // Map bit of probe tile, 1 cycle late
    input  logic       phase_end,    // From walker
    output tile_x_t    probe_x,
    output tile_y_t    probe_y,
    output tile_x_t    player_x,
    output tile_y_t    player_y,
    output phase_t     phase,
    output logic       phase_start,
    output logic       busy,
    output logic       frame_done
);

    typedef enum logic [2:0] {
        s_idle, s_probe, s_move, s_start, s_render, s_drain, s_done
    } state_t;

    state_t  state;
    tile_x_t next_x;
    tile_y_t next_y;
    logic    edge_hit;      // Neighbour off the grid
    logic    blocked;       // Latched edge_hit for this step
    logic    drain_count;
    logic    phase_open;    // Walker has a phase in progress

    // Neighbour tile in the requested direction
    always_comb begin
        next_x   = player_x;
        next_y   = player_y;
        edge_hit = 1'b0;
        case (direction)
            up:    if (player_y == '0) edge_hit = 1'b1;
                   else next_y = player_y - 1'b1;
            left:  if (player_x == '0) edge_hit = 1'b1;
                   else next_x = player_x - 1'b1;
            down:  if (player_y == tile_y_t'(grid_h - 1)) edge_hit = 1'b1;
                   else next_y = player_y + 1'b1;
            default: if (player_x == tile_x_t'(grid_w - 1)) edge_hit = 1'b1;
                     else next_x = player_x + 1'b1;
        endcase
    end

    // Own tile at the edge keeps the map read in range
    always_ff @(posedge clock) begin
        if (state == s_idle && step) begin
            probe_x <= next_x;
            probe_y <= next_y;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state       <= s_idle;
            player_x    <= start_tile_x;
            player_y    <= start_tile_y;
            phase       <= draw_maze;
            blocked     <= 1'b0;
            drain_count <= 1'b0;
            phase_open  <= 1'b0;
        end else begin
            if (phase_start) phase_open <= 1'b1;
            else if (phase_end) phase_open <= 1'b0;
            case (state)
                s_idle: if (step) begin   // Steps while busy never get here
                    blocked <= edge_hit;
                    state   <= s_probe;
                end
                s_probe: state <= s_move;   // Map read in flight
                s_move: begin
                    if (!blocked && !probe_wall) begin
                        player_x <= probe_x;
                        player_y <= probe_y;
                    end
                    phase <= draw_maze;
                    state <= s_start;
                end
                s_start: state <= s_render;
                s_render: if (phase_end) begin
                    case (phase)
                        draw_maze: begin phase <= draw_food; state <= s_start; end
                        draw_food: begin phase <= draw_player; state <= s_start; end
                        default:   begin drain_count <= 1'b0; state <= s_drain; end
                    endcase
                end
                s_drain: begin   // Two cycles for lookup and memory write
                    drain_count <= 1'b1;
                    if (drain_count) state <= s_done;
                end
                default: state <= s_idle;
            endcase
        end
    end

    assign phase_start = (state == s_start);
    assign busy        = (state != s_idle);
    assign frame_done  = (state == s_done);

    // Walker closes only a phase that is open
    a_end_in_phase: assert property (@(posedge clock) disable iff (!resetn)
        phase_end |-> phase_open);

endmodule

`default_nettype wire

//--- source/tile_walker.sv
`timescale 1ns/1ps
`default_nettype none

module tile_walker
    import maze_geometry_pkg::*, render_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  phase_t     phase,
    input  logic       phase_start,
    input  tile_x_t    player_x,
    input  tile_y_t    player_y,
    output walk_item_t item,
    output logic       phase_end
);

    logic    active;
    phase_t  walk_phase;   // Phase latched at start
    tile_x_t tx;
    tile_y_t ty;
    sub_t    dx;
    sub_t    dy;
    logic    sub_done;     // Last pixel of a tile
    logic    tile_done;    // Last tile of the grid
    logic    last;

    always_comb begin
        sub_done  = (dx == sub_t'(tile_px - 1)) && (dy == sub_t'(tile_px - 1));
        tile_done = (tx == tile_x_t'(grid_w - 1)) && (ty == tile_y_t'(grid_h - 1));
        case (walk_phase)
            draw_maze: last = sub_done && tile_done;   // 9425 items
            draw_food: last = tile_done;               // 377 items
            default:   last = sub_done;                // 25 items
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            active     <= 1'b0;
            item.valid <= 1'b0;
            phase_end  <= 1'b0;
        end else begin
            if (phase_start) active <= 1'b1;
            else if (active && last) active <= 1'b0;
            item.valid <= active;
            phase_end  <= item.valid && !active;   // Cycle after the last item
        end
    end

    // Counters and item payload
    always_ff @(posedge clock) begin
        if (phase_start) begin
            walk_phase <= phase;
            tx <= '0;
            ty <= '0;
            dx <= '0;
            dy <= '0;
        end else if (active) begin
            // Sub-tile offsets with dx innermost
            if (walk_phase != draw_food) begin
                if (dx == sub_t'(tile_px - 1)) begin
                    dx <= '0;
                    dy <= (dy == sub_t'(tile_px - 1)) ? '0 : dy + 1'b1;
                end else begin
                    dx <= dx + 1'b1;
                end
            end
            // Tile step once per tile for maze and every cycle for food
            if (walk_phase == draw_food || (walk_phase == draw_maze && sub_done)) begin
                if (tx == tile_x_t'(grid_w - 1)) begin
                    tx <= '0;
                    ty <= (ty == tile_y_t'(grid_h - 1)) ? '0 : ty + 1'b1;
                end else begin
                    tx <= tx + 1'b1;
                end
            end
        end
        item.phase  <= walk_phase;
        item.tile_x <= (walk_phase == draw_player) ? player_x : tx;
        item.tile_y <= (walk_phase == draw_player) ? player_y : ty;
        item.dx     <= dx;   // Zero for food as lookup adds the offset
        item.dy     <= dy;
    end

    // No new phase while items are still coming
    a_start_when_idle: assert property (@(posedge clock) disable iff (!resetn)
        phase_start |-> !active);

endmodule

`default_nettype wire

//--- source/tile_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tile_lookup
    import maze_geometry_pkg::*, render_pkg::*;
(
    input  logic         clock,
    input  walk_item_t   item,
    input  tile_x_t      probe_x,
    input  tile_y_t      probe_y,
    output pixel_write_t write,
    output logic         probe_wall
);

    // One row per word, bit index is tile column
    logic [grid_w-1:0] maze_rom [grid_h];

    sub_t      off_x;
    sub_t      off_y;
    canvas_x_t pix_x;
    canvas_y_t pix_y;
    logic      corner;

    // Stage registers
    logic     valid_q;
    phase_t   phase_q;
    fb_addr_t addr_q;
    logic     corner_q;
    logic     wall_q;
    logic     keep;

    initial $readmemb("maze_map.mem", maze_rom);

    always_comb begin
        off_x = item.dx;
        off_y = item.dy;
        if (item.phase == draw_food) begin   // Centre of the tile
            off_x = item.dx + sub_t'(food_offset);
            off_y = item.dy + sub_t'(food_offset);
        end
        pix_x = canvas_x_t'(item.tile_x) * canvas_x_t'(tile_px) + canvas_x_t'(off_x);
        pix_y = canvas_y_t'(item.tile_y) * canvas_y_t'(tile_px) + canvas_y_t'(off_y);
        // Rounded sprite, corners stay floor
        corner = (item.dx == '0 || item.dx == sub_t'(tile_px - 1))
              && (item.dy == '0 || item.dy == sub_t'(tile_px - 1));
    end

    always_ff @(posedge clock) begin
        valid_q    <= item.valid;
        phase_q    <= item.phase;
        addr_q     <= fb_addr_t'(pix_y) * fb_addr_t'(canvas_w) + fb_addr_t'(pix_x);
        corner_q   <= corner;
        wall_q     <= maze_rom[item.tile_y][item.tile_x];   // Item read port
        probe_wall <= maze_rom[probe_y][probe_x];           // Probe read port
    end

    // Color choice and write filter
    always_comb begin
        case (phase_q)
            draw_maze: begin
                keep        = 1'b1;
                write.color = wall_q ? color_wall : color_floor;
            end
            draw_food: begin
                keep        = !wall_q;   // Open tiles only
                write.color = color_food;
            end
            default: begin
                keep        = !corner_q;
                write.color = color_player;
            end
        endcase
        write.valid = valid_q && keep;
        write.addr  = addr_q;
    end

endmodule

`default_nettype wire

//--- source/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
    import maze_geometry_pkg::*, render_pkg::*;
(
    input  logic         clock,
    input  pixel_write_t write,
    input  fb_addr_t     read_addr,
    output color_t       read_color
);

    color_t canvas [canvas_words];   // 160 x 120, row major

    // Render side
    always_ff @(posedge clock) begin
        if (write.valid) canvas[write.addr] <= write.color;
    end

    // Scanout side, one cycle read
    always_ff @(posedge clock) begin
        read_color <= canvas[read_addr];
    end

    // Walker and lookup must keep writes on the canvas
    a_addr_range: assert property (@(posedge clock)
        write.valid |-> (write.addr < fb_addr_t'(canvas_words)));

endmodule

`default_nettype wire

//--- source/vga_scanout.sv
`timescale 1ns/1ps
`default_nettype none

module vga_scanout
    import maze_geometry_pkg::*, render_pkg::*;
(
    input  logic      clock,
    input  logic      resetn,
    input  color_t    read_color,   // Data for last cycle's address
    output fb_addr_t  read_addr,
    output canvas_x_t vga_x,
    output canvas_y_t vga_y,
    output color_t    vga_color,
    output logic      vga_valid
);

    canvas_x_t x_count;
    canvas_y_t y_count;
    fb_addr_t  addr_count;   // Tracks y * canvas_w + x without a multiplier

    always_ff @(posedge clock) begin
        if (!resetn) begin
            x_count    <= '0;
            y_count    <= '0;
            addr_count <= '0;
            vga_valid  <= 1'b0;
        end else begin
            vga_valid <= 1'b1;   // Free running once out of reset
            if (x_count == canvas_x_t'(canvas_w - 1)) begin
                x_count <= '0;
                if (y_count == canvas_y_t'(canvas_h - 1)) y_count <= '0;
                else y_count <= y_count + 1'b1;
            end else begin
                x_count <= x_count + 1'b1;
            end
            if (addr_count == fb_addr_t'(canvas_words - 1)) addr_count <= '0;
            else addr_count <= addr_count + 1'b1;
        end
    end

    // Coordinates delayed to meet the memory data
    always_ff @(posedge clock) begin
        vga_x <= x_count;
        vga_y <= y_count;
    end

    assign read_addr = addr_count;
    assign vga_color = read_color;   // Already registered in the buffer

endmodule

`default_nettype wire

//--- source/maze_top.sv
`timescale 1ns/1ps
`default_nettype none

module maze_top
    import maze_geometry_pkg::*, render_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       step,
    input  direction_t direction,
    output logic       busy,
    output logic       frame_done,
    output canvas_x_t  vga_x,
    output canvas_y_t  vga_y,
    output color_t     vga_color,
    output logic       vga_valid
);

    // Sequencer and walker
    tile_x_t      probe_x;
    tile_y_t      probe_y;
    logic         probe_wall;
    tile_x_t      player_x;
    tile_y_t      player_y;
    phase_t       phase;
    logic         phase_start;
    logic         phase_end;
    // Pipeline and memory
    walk_item_t   item;
    pixel_write_t write;
    fb_addr_t     read_addr;
    color_t       read_color;

    frame_sequencer i_sequencer (
        .clock       (clock),
        .resetn      (resetn),
        .step        (step),
        .direction   (direction),
        .probe_wall  (probe_wall),
        .phase_end   (phase_end),
        .probe_x     (probe_x),
        .probe_y     (probe_y),
        .player_x    (player_x),
        .player_y    (player_y),
        .phase       (phase),
        .phase_start (phase_start),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    tile_walker i_walker (
        .clock       (clock),
        .resetn      (resetn),
        .phase       (phase),
        .phase_start (phase_start),
        .player_x    (player_x),
        .player_y    (player_y),
        .item        (item),
        .phase_end   (phase_end)
    );

    tile_lookup i_lookup (
        .clock      (clock),
        .item       (item),
        .probe_x    (probe_x),
        .probe_y    (probe_y),
        .write      (write),
        .probe_wall (probe_wall)
    );

    frame_buffer i_frame_buffer (
        .clock      (clock),
        .write      (write),
        .read_addr  (read_addr),
        .read_color (read_color)
    );

    vga_scanout i_scanout (
        .clock      (clock),
        .resetn     (resetn),
        .read_color (read_color),
        .read_addr  (read_addr),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_color  (vga_color),
        .vga_valid  (vga_valid)
    );

endmodule

`default_nettype wire

//--- bench/maze_tb.sv
`timescale 1ns/1ps
`default_nettype none

module maze_tb
    import maze_geometry_pkg::*;
();

    // Expected geometry and colors
    localparam int cols    = 29;
    localparam int rows    = 13;
    localparam int tile    = 5;
    localparam int scr_w   = 160;
    localparam int scr_h   = 120;
    localparam int drawn_w = cols * tile;   // 145
    localparam int drawn_h = rows * tile;   // 65
    localparam logic [11:0] wall_rgb   = 12'h0FF;
    localparam logic [11:0] floor_rgb  = 12'h000;
    localparam logic [11:0] food_rgb   = 12'hFFF;
    localparam logic [11:0] player_rgb = 12'hFA8;

    localparam int table_len    = 13;
    localparam int random_steps = 20;
    // Render with drain plus worst wait for (0,0) and one full scan
    localparam int step_cycles     = 9425 + 377 + 25 + 32 + 2 * scr_w * scr_h;
    localparam int watchdog_cycles = (table_len + random_steps) * step_cycles
                                   + scr_w * scr_h + 20;   // Spare frame and reset

    typedef struct packed {
        direction_t dir;
        logic       poke;       // Extra step pulsed while busy
        direction_t poke_dir;
        logic [4:0] exp_x;      // Player tile after the step
        logic [3:0] exp_y;
    } step_entry_t;

    localparam step_entry_t step_table [table_len] = '{
        '{up,    1'b0, up,    5'd1, 4'd1},   // Border above start
        '{right, 1'b0, up,    5'd2, 4'd1},
        '{up,    1'b0, up,    5'd2, 4'd1},   // Border again
        '{down,  1'b0, up,    5'd2, 4'd1},   // Pillar at (2,2)
        '{right, 1'b0, up,    5'd3, 4'd1},
        '{down,  1'b0, up,    5'd3, 4'd2},
        '{down,  1'b0, up,    5'd3, 4'd3},
        '{left,  1'b0, up,    5'd2, 4'd3},
        '{left,  1'b0, up,    5'd1, 4'd3},
        '{up,    1'b0, up,    5'd1, 4'd2},
        '{left,  1'b0, up,    5'd1, 4'd2},   // Left border
        '{down,  1'b1, right, 5'd1, 4'd3},   // Poke right must be dropped
        '{right, 1'b0, up,    5'd2, 4'd3}
    };

    logic        clock;
    logic        resetn;
    logic        step;
    direction_t  direction;
    logic        busy;
    logic        frame_done;
    canvas_x_t   vga_x;
    canvas_y_t   vga_y;
    logic [11:0] vga_color;
    logic        vga_valid;

    int          model_x = 1;   // Player tile in the model
    int          model_y = 1;
    int          error_count = 0;
    int          check_count = 0;
    int          done_count = 0;
    logic        done_prev = 1'b0;
    logic [31:0] rng = 32'hfa0cadba;
    direction_t  rand_dir;

    maze_top i_dut (
        .clock      (clock),
        .resetn     (resetn),
        .step       (step),
        .direction  (direction),
        .busy       (busy),
        .frame_done (frame_done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_color  (vga_color),
        .vga_valid  (vga_valid)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;   // 40 ns period
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: no result after %0d clock cycles", watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

    // Counts frame_done pulses of one cycle each
    always @(negedge clock) begin
        if (resetn) begin
            if (frame_done) begin
                done_count = done_count + 1;
                if (done_prev) begin
                    error_count = error_count + 1;
                    $display("frame_done stayed high for more than one cycle at %0t", $time);
                end
            end
            done_prev = frame_done;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("** Error: %s = %0h, expected %0h (%0t)", name, actual, expected, $time);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Border plus even/even pillars
    function automatic logic is_wall(input int x, input int y);
        return x == 0 || y == 0 || x == cols - 1 || y == rows - 1
            || (x % 2 == 0 && y % 2 == 0);
    endfunction

    function automatic logic [11:0] expected_pixel(input int px, input int py);
        int          tx;
        int          ty;
        int          sx;
        int          sy;
        logic [11:0] rgb;
        tx = px / tile;
        ty = py / tile;
        sx = px % tile;
        sy = py % tile;
        rgb = is_wall(tx, ty) ? wall_rgb : floor_rgb;
        if (!is_wall(tx, ty) && sx == 2 && sy == 2) rgb = food_rgb;   // Dot at centre
        // Sprite over everything except its corners
        if (tx == model_x && ty == model_y
            && !((sx == 0 || sx == tile - 1) && (sy == 0 || sy == tile - 1)))
            rgb = player_rgb;
        return rgb;
    endfunction

    task automatic predict_move(input direction_t dir);
        int nx;
        int ny;
        nx = model_x;
        ny = model_y;
        case (dir)
            up:      ny = ny - 1;
            left:    nx = nx - 1;
            down:    ny = ny + 1;
            default: nx = nx + 1;
        endcase
        // Off grid or wall leaves the player in place
        if (nx >= 0 && nx < cols && ny >= 0 && ny < rows && !is_wall(nx, ny)) begin
            model_x = nx;
            model_y = ny;
        end
    endtask

    task automatic apply_step(input direction_t dir, input logic poke,
                              input direction_t poke_dir);
        @(negedge clock);
        direction = dir;
        step      = 1'b1;
        @(negedge clock);
        step = 1'b0;
        check_value("busy", busy, 1);   // Step taken
        if (poke) begin
            repeat (4) @(negedge clock);
            check_value("busy", busy, 1);
            direction = poke_dir;
            step      = 1'b1;
            @(negedge clock);
            step = 1'b0;
        end
        while (!frame_done) @(negedge clock);
        @(negedge clock);
        check_value("busy", busy, 0);   // Drops right after frame_done
    endtask

    // One whole scanout frame with colors only where the maze is drawn
    task automatic check_frame();
        int px;
        int py;
        while (!(vga_valid && vga_x == 0 && vga_y == 0)) @(negedge clock);
        for (int i = 0; i < scr_w * scr_h; i++) begin
            if (i > 0) @(negedge clock);
            px = i % scr_w;
            py = i / scr_w;
            check_value("vga_valid", vga_valid, 1);
            check_value("vga_x", vga_x, px);
            check_value("vga_y", vga_y, py);
            if (px < drawn_w && py < drawn_h)
                check_value($sformatf("vga_color at (%0d,%0d)", px, py),
                            vga_color, expected_pixel(px, py));
        end
    endtask

    initial begin
        resetn    = 1'b0;
        step      = 1'b0;
        direction = up;
        repeat (10) @(negedge clock);
        check_value("busy", busy, 0);
        check_value("frame_done", frame_done, 0);
        check_value("vga_valid", vga_valid, 0);
        resetn = 1'b1;

        // Directed moves from the table
        for (int i = 0; i < table_len; i++) begin
            apply_step(step_table[i].dir, step_table[i].poke, step_table[i].poke_dir);
            model_x = int'(step_table[i].exp_x);
            model_y = int'(step_table[i].exp_y);
            check_frame();
        end

        // Random walk that the model predicts
        for (int i = 0; i < random_steps; i++) begin
            rng      = xorshift(rng);
            rand_dir = direction_t'(rng[1:0]);
            predict_move(rand_dir);
            apply_step(rand_dir, 1'b0, up);
            check_frame();
        end

        check_value("frame_done count", done_count, table_len + random_steps);
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/maze_map.mem
11111111111111111111111111111
10000000000000000000000000001
10101010101010101010101010101
10000000000000000000000000001
10101010101010101010101010101
10000000000000000000000000001
10101010101010101010101010101
10000000000000000000000000001
10101010101010101010101010101
10000000000000000000000000001
10101010101010101010101010101
10000000000000000000000000001
11111111111111111111111111111

//--- files.f
source/maze_geometry_pkg.sv
source/render_pkg.sv
source/frame_sequencer.sv
source/tile_walker.sv
source/tile_lookup.sv
source/frame_buffer.sv
source/vga_scanout.sv
source/maze_top.sv
bench/maze_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run from source/ where the maze map is read
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module maze_tb -f files.f -o Vmaze_tb \
    && (cd source && ../obj_dir/Vmaze_tb) > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
grep -qsx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
